//--- verilog/collider_defines.svh
`ifndef COLLIDER_DEFINES_SVH
`define COLLIDER_DEFINES_SVH

// screen coordinate width
`define COLLIDER_POS_W 16

// sprite is 48 wide and 48 high
`define PLAYER_HALF_W 24
`define PLAYER_H 48

// arena limits used when no map rule applies
`define ARENA_X_MIN 23
`define ARENA_X_MAX 617
`define ARENA_Y_MIN 14
`define ARENA_Y_MAX 463

// centre x at and above which only the arena limits apply
`define MAP_SPLIT_X 320

`endif

//--- verilog/collider_pkg.sv
`include "collider_defines.svh"

package collider_pkg;

    // unsigned screen coordinate
    typedef logic [`COLLIDER_POS_W-1:0] pos_t;

    // map columns named after their exclusive upper bound on centre x
    typedef enum logic [3:0] {
        col_88,
        col_102,
        col_169,
        col_200,
        col_215,
        col_256,
        col_280,
        col_296,
        col_320,
        // right half of the screen keeps the arena limits
        col_right
    } column_t;

endpackage

//--- verilog/collider_stage_if.sv
`timescale 1ns/1ps

// classified position between column and row stages
interface collider_stage_if;
    import collider_pkg::*;

    column_t column;
    pos_t    pos_y;
    logic    valid;
    logic    ready;

    modport source (
        output column,
        output pos_y,
        output valid,
        input  ready
    );

    modport sink (
        input  column,
        input  pos_y,
        input  valid,
        output ready
    );

endinterface

//--- verilog/column_classifier.sv
`timescale 1ns/1ps
`include "collider_defines.svh"

module column_classifier (
    input  logic                clk,
    input  logic                rst_n,
    input  collider_pkg::pos_t  pos_x,
    input  collider_pkg::pos_t  pos_y,
    input  logic                in_valid,
    output logic                in_ready,
    collider_stage_if.source    stage
);
    import collider_pkg::*;

    logic [`COLLIDER_POS_W:0] centre_x;
    column_t                  column_d;
    column_t                  column_q;
    pos_t                     pos_y_q;
    logic                     valid_q;

    // one extra bit so the sum never wraps
    assign centre_x = {1'b0, pos_x} + (`COLLIDER_POS_W+1)'(`PLAYER_HALF_W);

    always_comb begin
        if (centre_x < 88) begin
            column_d = col_88;
        end else if (centre_x < 102) begin
            column_d = col_102;
        end else if (centre_x < 169) begin
            column_d = col_169;
        end else if (centre_x < 200) begin
            column_d = col_200;
        end else if (centre_x < 215) begin
            column_d = col_215;
        end else if (centre_x < 256) begin
            column_d = col_256;
        end else if (centre_x < 280) begin
            column_d = col_280;
        end else if (centre_x < 296) begin
            column_d = col_296;
        end else if (centre_x < `MAP_SPLIT_X) begin
            column_d = col_320;
        end else begin
            column_d = col_right;
        end
    end

    // empty, or the held item leaves on this edge
    assign in_ready = !valid_q || stage.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_valid && in_ready) begin
            valid_q <= 1'b1;
        end else if (stage.ready) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            column_q <= column_d;
            pos_y_q  <= pos_y;
        end
    end

    assign stage.column = column_q;
    assign stage.pos_y  = pos_y_q;
    assign stage.valid  = valid_q;

endmodule

//--- verilog/wall_lookup.sv
`timescale 1ns/1ps
`include "collider_defines.svh"

module wall_lookup (
    input  logic                clk,
    input  logic                rst_n,
    collider_stage_if.sink      stage,
    output collider_pkg::pos_t  x_min,
    output collider_pkg::pos_t  x_max,
    output collider_pkg::pos_t  y_min,
    output collider_pkg::pos_t  y_max,
    output logic                out_valid,
    input  logic                out_ready
);
    import collider_pkg::*;

    pos_t                     py;
    logic [`COLLIDER_POS_W:0] foot_y;
    pos_t                     nx_min;
    pos_t                     nx_max;
    pos_t                     ny_min;
    pos_t                     ny_max;
    logic                     take;

    assign py     = stage.pos_y;
    assign foot_y = {1'b0, py} + (`COLLIDER_POS_W+1)'(`PLAYER_H);

    always_comb begin
        nx_min = pos_t'(`ARENA_X_MIN);
        nx_max = pos_t'(`ARENA_X_MAX);
        ny_min = pos_t'(`ARENA_Y_MIN);
        ny_max = pos_t'(`ARENA_Y_MAX);

        case (stage.column)
            col_88: begin
                if (py >= 400) begin
                    nx_max = 16'd571;
                    ny_min = 16'd400;
                end else if (py >= 336) begin
                    nx_max = 16'd256;
                    ny_min = 16'd336;
                    ny_max = 16'd399;
                end else if (py >= 129) begin
                    ny_min = 16'd192;
                    ny_max = 16'd335;
                    // foot inside the ledge band blocks the right side
                    if (py < 264 && foot_y > 255) begin
                        nx_max = 16'd88;
                    end
                end else begin
                    ny_max = 16'd128;
                end
            end
            col_102: begin
                if (py >= 400) begin
                    nx_max = 16'd571;
                    ny_min = 16'd400;
                end else if (py >= 336) begin
                    nx_max = 16'd256;
                    ny_min = 16'd336;
                    ny_max = 16'd399;
                end else if (py >= 257) begin
                    ny_min = 16'd257;
                    ny_max = 16'd335;
                end else if (py >= 129) begin
                    ny_min = 16'd191;
                    ny_max = 16'd256;
                end else begin
                    ny_max = 16'd128;
                end
            end
            col_169: begin
                if (py >= 400) begin
                    nx_max = 16'd571;
                    ny_min = 16'd400;
                end else if (py >= 336) begin
                    nx_max = 16'd256;
                    ny_min = 16'd336;
                    ny_max = 16'd399;
                end else if (py >= 257) begin
                    ny_min = 16'd257;
                    ny_max = 16'd335;
                end else if (py >= 193) begin
                    ny_min = 16'd193;
                    ny_max = 16'd256;
                end else if (py >= 129) begin
                    nx_min = 16'd102;
                    ny_max = 16'd192;
                end else begin
                    ny_max = 16'd192;
                    // low step on the right
                    if (py < 86 && foot_y > 78) begin
                        nx_max = 16'd169;
                    end
                end
            end
            col_200: begin
                if (py >= 400) begin
                    nx_max = 16'd571;
                    ny_min = 16'd400;
                end else if (py >= 336) begin
                    nx_max = 16'd256;
                    ny_min = 16'd336;
                    ny_max = 16'd399;
                end else if (py >= 257) begin
                    ny_min = 16'd257;
                    ny_max = 16'd335;
                end else if (py >= 193) begin
                    ny_min = 16'd193;
                    ny_max = 16'd256;
                end else if (py >= 79) begin
                    ny_min = 16'd79;
                    ny_max = 16'd192;
                    if (py < 138) begin
                        nx_max = 16'd200;
                    end
                end else begin
                    ny_max = 16'd78;
                end
            end
            col_215: begin
                if (py >= 400) begin
                    nx_max = 16'd571;
                    ny_min = 16'd400;
                end else if (py >= 336) begin
                    nx_max = 16'd256;
                    ny_min = 16'd336;
                    ny_max = 16'd399;
                end else if (py >= 257) begin
                    ny_min = 16'd257;
                    ny_max = 16'd335;
                end else if (py >= 193) begin
                    ny_min = 16'd193;
                    ny_max = 16'd256;
                end else if (py >= 76) begin
                    ny_min = 16'd138;
                    ny_max = 16'd192;
                end else begin
                    ny_max = 16'd78;
                end
            end
            col_256: begin
                if (py >= 336) begin
                    ny_min = 16'd336;
                    if (py >= 408) begin
                        nx_max = 16'd571;
                    end else if (foot_y <= 399) begin
                        nx_max = 16'd256;
                    end else begin
                        // foot below the platform edge
                        nx_min = 16'd215;
                    end
                end else if (py >= 257) begin
                    ny_min = 16'd257;
                    ny_max = 16'd335;
                end else if (py >= 193) begin
                    ny_min = 16'd193;
                    ny_max = 16'd256;
                end else if (py >= 95) begin
                    ny_min = 16'd138;
                    ny_max = 16'd192;
                end else begin
                    ny_max = 16'd94;
                end
            end
            col_280: begin
                if (py >= 336) begin
                    nx_max = 16'd571;
                    ny_min = 16'd372;
                end else if (py >= 257) begin
                    ny_min = 16'd257;
                    ny_max = 16'd335;
                end else if (py >= 193) begin
                    ny_min = 16'd193;
                    ny_max = 16'd256;
                end else if (py >= 109) begin
                    ny_min = 16'd138;
                    ny_max = 16'd192;
                end else begin
                    ny_min = 16'd38;
                    ny_max = 16'd110;
                end
            end
            col_296: begin
                if (py >= 344) begin
                    nx_max = 16'd571;
                    ny_min = 16'd366;
                end else if (py >= 257) begin
                    ny_min = 16'd257;
                    ny_max = 16'd343;
                end else if (py >= 193) begin
                    ny_min = 16'd193;
                    ny_max = 16'd256;
                end else if (py >= 109) begin
                    ny_min = 16'd109;
                    ny_max = 16'd192;
                    if (py < 138) begin
                        nx_min = 16'd279;
                    end
                end else begin
                    ny_min = 16'd38;
                    ny_max = 16'd110;
                end
            end
            col_320: begin
                if (py >= 354) begin
                    nx_max = 16'd571;
                    ny_min = 16'd366;
                    ny_max = 16'd472;
                end else if (py >= 257) begin
                    ny_min = 16'd271;
                    ny_max = 16'd353;
                end else if (py >= 193) begin
                    ny_min = 16'd193;
                    ny_max = 16'd256;
                end else if (py >= 109) begin
                    ny_min = 16'd109;
                    ny_max = 16'd192;
                end else begin
                    ny_min = 16'd38;
                    ny_max = 16'd110;
                end
            end
            default: begin
                // col_right keeps the arena limits
            end
        endcase
    end

    // empty, or the response leaves on this edge
    assign stage.ready = !out_valid || out_ready;
    assign take        = stage.valid && stage.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (take) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            x_min <= nx_min;
            x_max <= nx_max;
            y_min <= ny_min;
            y_max <= ny_max;
        end
    end

endmodule

//--- verilog/collider_top.sv
`timescale 1ns/1ps

module collider_top (
    input  logic                clk,
    input  logic                rst_n,
    input  collider_pkg::pos_t  pos_x,
    input  collider_pkg::pos_t  pos_y,
    input  logic                in_valid,
    output logic                in_ready,
    output collider_pkg::pos_t  x_min,
    output collider_pkg::pos_t  x_max,
    output collider_pkg::pos_t  y_min,
    output collider_pkg::pos_t  y_max,
    output logic                out_valid,
    input  logic                out_ready
);

    collider_stage_if stage_if ();

    // column decode in the first register stage
    column_classifier column_classifier_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pos_x    (pos_x),
        .pos_y    (pos_y),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .stage    (stage_if.source)
    );

    // row decode and limit registers
    wall_lookup wall_lookup_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .stage     (stage_if.sink),
        .x_min     (x_min),
        .x_max     (x_max),
        .y_min     (y_min),
        .y_max     (y_max),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

//--- tests/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk = ~clk;
        end
    end

    // release just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;
    end

endmodule

//--- tests/collider_tb.sv
`timescale 1ns/1ps
`include "collider_defines.svh"

module collider_tb;
    import collider_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_PROBES = 6;
    localparam int NUM_FULL   = 16;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_REQ    = NUM_FULL + NUM_RANDOM;
    localparam int LIM_W      = 4 * `COLLIDER_POS_W;

    logic             clk;
    logic             rst_n;
    pos_t             pos_x;
    pos_t             pos_y;
    logic             in_valid;
    logic             in_ready;
    pos_t             x_min;
    pos_t             x_max;
    pos_t             y_min;
    pos_t             y_max;
    logic             out_valid;
    logic             out_ready;

    integer           seed;
    integer           cycle;
    integer           resp_count;
    logic             full_rate;
    logic             bp_on;
    logic [LIM_W-1:0] cur_lim;
    logic [LIM_W-1:0] head_lim;
    integer           head_cycle;
    logic             head_valid;

    pos_t             probe_x [NUM_PROBES];
    pos_t             probe_y [NUM_PROBES];
    logic [LIM_W-1:0] probe_lim [NUM_PROBES];
    pos_t             req_x [NUM_REQ];
    pos_t             req_y [NUM_REQ];
    logic [LIM_W-1:0] req_lim [NUM_REQ];

    // expected limits and accept cycle in request order
    logic [LIM_W-1:0] exp_q [$];
    integer           acc_q [$];

    clock_gen clock_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    collider_top collider_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pos_x     (pos_x),
        .pos_y     (pos_y),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .x_min     (x_min),
        .x_max     (x_max),
        .y_min     (y_min),
        .y_max     (y_max),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("Error at %0t: %s", $time, msg));
    endtask

    function automatic logic [LIM_W-1:0] pack_limits(input int xl, input int xh,
                                                     input int yl, input int yh);
        return {pos_t'(xl), pos_t'(xh), pos_t'(yl), pos_t'(yh)};
    endfunction

    function automatic logic [LIM_W-1:0] arena_limits();
        return pack_limits(`ARENA_X_MIN, `ARENA_X_MAX, `ARENA_Y_MIN, `ARENA_Y_MAX);
    endfunction

    task automatic set_probe(input int idx, input int x, input int y,
                             input logic [LIM_W-1:0] lim);
        probe_x[idx]   = pos_t'(x);
        probe_y[idx]   = pos_t'(y);
        probe_lim[idx] = lim;
    endtask

    // known map points of the left half
    task automatic load_probes();
        set_probe(0, 0, 420, pack_limits(23, 571, 400, 463));
        set_probe(1, 0, 50, pack_limits(23, 617, 14, 128));
        set_probe(2, 0, 200, pack_limits(23, 617, 192, 335));
        set_probe(3, 0, 220, pack_limits(23, 88, 192, 335));
        set_probe(4, 100, 150, pack_limits(102, 617, 14, 192));
        set_probe(5, 250, 50, pack_limits(23, 617, 38, 110));
    endtask

    task automatic set_right_half(input int idx);
        req_x[idx]   = pos_t'(296 + ($random(seed) & 16'h7fff));
        req_y[idx]   = pos_t'($random(seed));
        req_lim[idx] = arena_limits();
    endtask

    task automatic build_requests();
        int pick;
        for (int i = 0; i < NUM_PROBES; i++) begin
            req_x[i]   = probe_x[i];
            req_y[i]   = probe_y[i];
            req_lim[i] = probe_lim[i];
        end
        // right-half edges and random right-half points
        req_x[6]   = 16'd296;
        req_y[6]   = 16'd0;
        req_lim[6] = arena_limits();
        req_x[7]   = 16'hffff;
        req_y[7]   = 16'hffff;
        req_lim[7] = arena_limits();
        for (int i = 8; i < NUM_FULL; i++) begin
            set_right_half(i);
        end
        for (int i = NUM_FULL; i < NUM_REQ; i++) begin
            pick = $random(seed) & 7;
            if (pick < NUM_PROBES) begin
                req_x[i]   = probe_x[pick];
                req_y[i]   = probe_y[pick];
                req_lim[i] = probe_lim[pick];
            end else begin
                set_right_half(i);
            end
        end
    endtask

    // holds the request until the DUT takes it
    task automatic send_request(input int idx);
        pos_x    = req_x[idx];
        pos_y    = req_y[idx];
        cur_lim  = req_lim[idx];
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // handshakes seen mid-cycle complete on the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (out_valid && out_ready) begin
                head_valid = (exp_q.size() > 0);
                if (head_valid) begin
                    head_lim   = exp_q.pop_front();
                    head_cycle = acc_q.pop_front();
                end
                resp_count = resp_count + 1;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(cur_lim);
                acc_q.push_back(cycle);
            end
        end
    end

    always @(posedge clk) begin
        #2;
        if (bp_on) begin
            out_ready = ($random(seed) % 2) != 0;
        end else begin
            out_ready = 1'b1;
        end
    end

    assert property (@(posedge clk) $rose(rst_n) |-> (!out_valid && in_ready))
        else value_error("pipeline not idle after reset");

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_ready) |-> (head_valid && {x_min, x_max, y_min, y_max} == head_lim))
        else value_error($sformatf("limits %0d %0d %0d %0d, expected %0d %0d %0d %0d",
            x_min, x_max, y_min, y_max, head_lim[63:48], head_lim[47:32],
            head_lim[31:16], head_lim[15:0]));

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(x_min) && $stable(x_max)
            && $stable(y_min) && $stable(y_max)))
        else value_error("response changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n) full_rate |-> in_ready)
        else value_error("in_ready dropped without back-pressure");

    assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out_ready && full_rate) |-> (cycle - head_cycle == 2))
        else value_error($sformatf("latency %0d edges, expected 2", cycle - head_cycle));

    initial begin
        #((NUM_REQ * 10 + 50) * CLK_PERIOD);
        abort_run("Timeout: the pipeline stopped returning responses");
    end

    initial begin
        seed       = 94;
        cycle      = 0;
        resp_count = 0;
        head_valid = 1'b0;
        head_lim   = '0;
        head_cycle = 0;
        pos_x      = '0;
        pos_y      = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        cur_lim    = '0;
        full_rate  = 1'b0;
        bp_on      = 1'b0;
        load_probes();
        build_requests();

        wait (rst_n === 1'b1);
        @(posedge clk);
        #2;

        // back-to-back requests without stalls
        full_rate = 1'b1;
        for (int i = 0; i < NUM_FULL; i++) begin
            send_request(i);
        end
        in_valid = 1'b0;
        wait_drain();
        full_rate = 1'b0;

        // random stalls on the response side
        bp_on = 1'b1;
        for (int i = NUM_FULL; i < NUM_REQ; i++) begin
            send_request(i);
            if (i % 3 == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #2;
            end
        end
        in_valid = 1'b0;
        wait_drain();
        bp_on = 1'b0;

        if (resp_count == NUM_REQ && exp_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            value_error($sformatf("%0d responses, expected %0d", resp_count, NUM_REQ));
        end
    end

endmodule

//--- flist.f
+incdir+verilog
verilog/collider_pkg.sv
verilog/collider_stage_if.sv
verilog/column_classifier.sv
verilog/wall_lookup.sv
verilog/collider_top.sv
tests/clock_gen.sv
tests/collider_tb.sv

//--- Bender.yml
package:
  name: collider

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/collider_pkg.sv
      - verilog/collider_stage_if.sv
      - verilog/column_classifier.sv
      - verilog/wall_lookup.sv
      - verilog/collider_top.sv
  - target: test
    files:
      - tests/clock_gen.sv
      - tests/collider_tb.sv
